// ==== common/exec_pipe_defines.svh ====
`ifndef EXEC_PIPE_DEFINES_SVH
`define EXEC_PIPE_DEFINES_SVH

// Operand word width
`define EP_DATA_W     32

// Register file geometry
`define EP_REG_ADDR_W 5
`define EP_NUM_REGS   32

// Shift distance field
`define EP_SHAMT_W    5

`endif

// ==== common/exec_pipe_pkg.sv ====
`default_nettype none

`include "exec_pipe_defines.svh"

package exec_pipe_pkg;

    typedef logic [`EP_DATA_W-1:0]     data_t;
    typedef logic [`EP_REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [`EP_SHAMT_W-1:0]    shamt_t;

    // ADD and SUB are the trapping forms
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_ADDU = 4'd1,
        ALU_SUB  = 4'd2,
        ALU_SUBU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd5,
        ALU_XOR  = 4'd6,
        ALU_NOR  = 4'd7,
        ALU_SLT  = 4'd8,
        ALU_SLTU = 4'd9,
        ALU_LUI  = 4'd10
    } alu_op_e;

    typedef enum logic [1:0] {SH_SLL = 2'd0, SH_SRL = 2'd1, SH_SRA = 2'd2} shift_op_e;

    typedef enum logic [1:0] {RES_ALU = 2'd0, RES_SHIFT = 2'd1, RES_MOVE = 2'd2} res_sel_e;

    typedef enum logic [1:0] {
        MOVE_ALWAYS     = 2'd0,
        MOVE_IF_ZERO    = 2'd1,
        MOVE_IF_NONZERO = 2'd2
    } move_cond_e;

    typedef enum logic [1:0] {FROM_REG = 2'd0, FROM_MEM = 2'd1, FROM_WB = 2'd2} fwd_sel_e;

    // Pre-decoded operation with imm already extended by the issuer
    typedef struct packed {
        alu_op_e    alu_op;
        shift_op_e  shift_op;
        res_sel_e   res_sel;
        move_cond_e move_cond;
        logic       b_imm;
        logic       shamt_reg;
        shamt_t     shamt;
        data_t      imm;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic       reg_w;
        logic       trap_of;
    } micro_op_t;

    // Contents of EX/MEM and MEM/WB
    typedef struct packed {
        logic      retire;
        logic      reg_w;
        reg_addr_t rd;
        data_t     data;
    } stage_result_t;

endpackage

`default_nettype wire

// ==== exec_pipe.f ====
+incdir+common
common/exec_pipe_pkg.sv
execute/alu.sv
execute/barrel_shifter.sv
execute/forward_unit.sv
execute/execute_stage.sv
hdl/writeback_unit.sv
hdl/exec_pipe.sv
testbench/exec_pipe_assertions.sv
testbench/exec_pipe_tb.sv

// ==== execute/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_pipe_defines.svh"

module alu (
    input  wire exec_pipe_pkg::data_t    a,
    input  wire exec_pipe_pkg::data_t    b,
    input  wire exec_pipe_pkg::alu_op_e  op,
    output exec_pipe_pkg::data_t         result,
    output logic                         overflow
);

    localparam int MSB = `EP_DATA_W - 1;

    exec_pipe_pkg::data_t sum;
    exec_pipe_pkg::data_t diff;

    assign sum  = a + b;
    assign diff = a - b;

    always_comb begin
        overflow = 1'b0;
        case (op)
            exec_pipe_pkg::ALU_ADD: begin
                result   = sum;
                overflow = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
            end
            exec_pipe_pkg::ALU_SUB: begin
                result   = diff;
                overflow = (a[MSB] != b[MSB]) && (diff[MSB] != a[MSB]);
            end
            exec_pipe_pkg::ALU_ADDU: result = sum;
            exec_pipe_pkg::ALU_SUBU: result = diff;
            exec_pipe_pkg::ALU_AND:  result = a & b;
            exec_pipe_pkg::ALU_OR:   result = a | b;
            exec_pipe_pkg::ALU_XOR:  result = a ^ b;
            exec_pipe_pkg::ALU_NOR:  result = ~(a | b);
            exec_pipe_pkg::ALU_SLT:  result = exec_pipe_pkg::data_t'($signed(a) < $signed(b));
            exec_pipe_pkg::ALU_SLTU: result = exec_pipe_pkg::data_t'(a < b);
            // Immediate lands in the upper half
            exec_pipe_pkg::ALU_LUI:  result = b << (`EP_DATA_W / 2);
            default:                 result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== execute/barrel_shifter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_pipe_defines.svh"

module barrel_shifter (
    input  wire exec_pipe_pkg::data_t       shift_in,
    input  wire exec_pipe_pkg::shamt_t      amount,
    input  wire exec_pipe_pkg::shift_op_e   op,
    output exec_pipe_pkg::data_t            shift_out
);

    localparam int W = `EP_DATA_W;

    logic fill;

    // Sign fill only for arithmetic right shift
    assign fill = (op == exec_pipe_pkg::SH_SRA) ? shift_in[W-1] : 1'b0;

    // One level per amount bit, distance doubling each level
    always_comb begin
        exec_pipe_pkg::data_t level;
        logic [2*W-1:0]       wide;
        level = shift_in;
        wide  = '0;
        for (int i = 0; i < `EP_SHAMT_W; i++) begin
            if (amount[i]) begin
                if (op == exec_pipe_pkg::SH_SLL) begin
                    level = level << (1 << i);
                end else begin
                    wide  = {{W{fill}}, level} >> (1 << i);
                    level = wide[W-1:0];
                end
            end
        end
        shift_out = level;
    end

endmodule

`default_nettype wire

// ==== execute/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_pipe_defines.svh"

module execute_stage (
    input  wire                                ui_clk_from_ddr,
    input  wire                                rst_n,
    input  wire                                issue,
    input  wire exec_pipe_pkg::micro_op_t      uop,
    input  wire exec_pipe_pkg::data_t          rs_data,
    input  wire exec_pipe_pkg::data_t          rt_data,
    input  wire exec_pipe_pkg::fwd_sel_e       a_sel,
    input  wire exec_pipe_pkg::fwd_sel_e       b_sel,
    input  wire exec_pipe_pkg::stage_result_t  wb,
    output exec_pipe_pkg::reg_addr_t           ex_rs,
    output exec_pipe_pkg::reg_addr_t           ex_rt,
    output exec_pipe_pkg::stage_result_t       mem_stage
);

    logic                     idex_valid;
    logic                     idex_reg_w;
    exec_pipe_pkg::micro_op_t idex_uop;
    exec_pipe_pkg::data_t     idex_rs_data;
    exec_pipe_pkg::data_t     idex_rt_data;

    exec_pipe_pkg::data_t     op_a;
    exec_pipe_pkg::data_t     op_b;
    exec_pipe_pkg::data_t     alu_b;
    exec_pipe_pkg::data_t     alu_out;
    exec_pipe_pkg::data_t     shift_out;
    exec_pipe_pkg::data_t     ex_result;
    exec_pipe_pkg::shamt_t    shift_amt;
    logic                     overflow;
    logic                     move_ok;
    logic                     ex_reg_w;

    function automatic exec_pipe_pkg::data_t fwd_mux(
        input exec_pipe_pkg::fwd_sel_e sel,
        input exec_pipe_pkg::data_t    reg_val,
        input exec_pipe_pkg::data_t    mem_val,
        input exec_pipe_pkg::data_t    wb_val
    );
        case (sel)
            exec_pipe_pkg::FROM_MEM: return mem_val;
            exec_pipe_pkg::FROM_WB:  return wb_val;
            default:                 return reg_val;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // ID/EX register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            idex_valid <= 1'b0;
            idex_reg_w <= 1'b0;
        end else begin
            idex_valid <= issue;
            idex_reg_w <= issue && uop.reg_w;
        end
        if (issue) begin
            idex_uop     <= uop;
            idex_rs_data <= rs_data;
            idex_rt_data <= rt_data;
        end
    end

    assign ex_rs = idex_uop.rs;
    assign ex_rt = idex_uop.rt;

    // Bypassed operands, then B and shift amount sources
    assign op_a      = fwd_mux(a_sel, idex_rs_data, mem_stage.data, wb.data);
    assign op_b      = fwd_mux(b_sel, idex_rt_data, mem_stage.data, wb.data);
    assign alu_b     = idex_uop.b_imm ? idex_uop.imm : op_b;
    assign shift_amt = idex_uop.shamt_reg ? op_a[`EP_SHAMT_W-1:0] : idex_uop.shamt;

    alu u_alu (
        .a        ( op_a            ),
        .b        ( alu_b           ),
        .op       ( idex_uop.alu_op ),
        .result   ( alu_out         ),
        .overflow ( overflow        )
    );

    barrel_shifter u_barrel_shifter (
        .shift_in  ( op_b              ),
        .amount    ( shift_amt         ),
        .op        ( idex_uop.shift_op ),
        .shift_out ( shift_out         )
    );

    always_comb begin
        case (idex_uop.res_sel)
            exec_pipe_pkg::RES_SHIFT: ex_result = shift_out;
            exec_pipe_pkg::RES_MOVE:  ex_result = op_a;
            default:                  ex_result = alu_out;
        endcase
    end

    // Conditional move tests the rt value
    always_comb begin
        case (idex_uop.move_cond)
            exec_pipe_pkg::MOVE_IF_ZERO:    move_ok = (op_b == '0);
            exec_pipe_pkg::MOVE_IF_NONZERO: move_ok = (op_b != '0);
            default:                        move_ok = 1'b1;
        endcase
    end

    assign ex_reg_w = idex_reg_w && !(idex_uop.trap_of && overflow) && move_ok
                      && (idex_uop.rd != '0);

    ////////////////////////////////////////////////////////////
    // EX/MEM register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            mem_stage.retire <= 1'b0;
            mem_stage.reg_w  <= 1'b0;
        end else begin
            mem_stage.retire <= idex_valid;
            mem_stage.reg_w  <= ex_reg_w;
        end
        mem_stage.rd   <= idex_uop.rd;
        mem_stage.data <= ex_result;
    end

endmodule

`default_nettype wire

// ==== execute/forward_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module forward_unit (
    input  wire exec_pipe_pkg::reg_addr_t      ex_rs,
    input  wire exec_pipe_pkg::reg_addr_t      ex_rt,
    input  wire exec_pipe_pkg::stage_result_t  mem_stage,
    input  wire exec_pipe_pkg::stage_result_t  wb,
    output exec_pipe_pkg::fwd_sel_e            a_sel,
    output exec_pipe_pkg::fwd_sel_e            b_sel
);

    // Youngest producer wins, so MEM is checked before WB
    function automatic exec_pipe_pkg::fwd_sel_e pick_source(
        input exec_pipe_pkg::reg_addr_t     addr,
        input exec_pipe_pkg::stage_result_t mem_s,
        input exec_pipe_pkg::stage_result_t wb_s
    );
        if (mem_s.reg_w && mem_s.rd != '0 && mem_s.rd == addr)
            return exec_pipe_pkg::FROM_MEM;
        if (wb_s.reg_w && wb_s.rd != '0 && wb_s.rd == addr)
            return exec_pipe_pkg::FROM_WB;
        return exec_pipe_pkg::FROM_REG;
    endfunction

    assign a_sel = pick_source(ex_rs, mem_stage, wb);
    assign b_sel = pick_source(ex_rt, mem_stage, wb);

endmodule

`default_nettype wire

// ==== hdl/exec_pipe.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipe (
    input  wire                              ui_clk_from_ddr,
    input  wire                              rst_n,
    input  wire                              issue,
    input  wire exec_pipe_pkg::micro_op_t     uop,
    output exec_pipe_pkg::stage_result_t     wb
);

    exec_pipe_pkg::data_t         rs_data;
    exec_pipe_pkg::data_t         rt_data;
    exec_pipe_pkg::fwd_sel_e      a_sel;
    exec_pipe_pkg::fwd_sel_e      b_sel;
    exec_pipe_pkg::reg_addr_t     ex_rs;
    exec_pipe_pkg::reg_addr_t     ex_rt;
    exec_pipe_pkg::stage_result_t mem_stage;

    // Operands are read straight from the issued op
    execute_stage u_execute_stage (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .issue           ( issue           ),
        .uop             ( uop             ),
        .rs_data         ( rs_data         ),
        .rt_data         ( rt_data         ),
        .a_sel           ( a_sel           ),
        .b_sel           ( b_sel           ),
        .wb              ( wb              ),
        .ex_rs           ( ex_rs           ),
        .ex_rt           ( ex_rt           ),
        .mem_stage       ( mem_stage       )
    );

    forward_unit u_forward_unit (
        .ex_rs     ( ex_rs     ),
        .ex_rt     ( ex_rt     ),
        .mem_stage ( mem_stage ),
        .wb        ( wb        ),
        .a_sel     ( a_sel     ),
        .b_sel     ( b_sel     )
    );

    writeback_unit u_writeback_unit (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .mem_stage       ( mem_stage       ),
        .rs_addr         ( uop.rs          ),
        .rt_addr         ( uop.rt          ),
        .rs_data         ( rs_data         ),
        .rt_data         ( rt_data         ),
        .wb              ( wb              )
    );

endmodule

`default_nettype wire

// ==== hdl/writeback_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_pipe_defines.svh"

module writeback_unit (
    input  wire                                ui_clk_from_ddr,
    input  wire                                rst_n,
    input  wire exec_pipe_pkg::stage_result_t  mem_stage,
    input  wire exec_pipe_pkg::reg_addr_t      rs_addr,
    input  wire exec_pipe_pkg::reg_addr_t      rt_addr,
    output exec_pipe_pkg::data_t               rs_data,
    output exec_pipe_pkg::data_t               rt_data,
    output exec_pipe_pkg::stage_result_t       wb
);

    exec_pipe_pkg::data_t gpr [`EP_NUM_REGS];

    // Write-first read with register 0 hardwired to zero
    function automatic exec_pipe_pkg::data_t read_port(
        input exec_pipe_pkg::reg_addr_t     addr,
        input exec_pipe_pkg::data_t         stored,
        input exec_pipe_pkg::stage_result_t wr
    );
        if (addr == '0)
            return '0;
        if (wr.reg_w && wr.rd == addr)
            return wr.data;
        return stored;
    endfunction

    ////////////////////////////////////////////////////////////
    // MEM/WB register
    ////////////////////////////////////////////////////////////
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            wb.retire <= 1'b0;
            wb.reg_w  <= 1'b0;
        end else begin
            wb.retire <= mem_stage.retire;
            wb.reg_w  <= mem_stage.reg_w;
        end
        wb.rd   <= mem_stage.rd;
        wb.data <= mem_stage.data;
    end

    // Array update one edge after the op shows on wb
    always_ff @(posedge ui_clk_from_ddr) begin
        if (!rst_n) begin
            for (int i = 0; i < `EP_NUM_REGS; i++)
                gpr[i] <= '0;
        end else if (wb.reg_w && wb.rd != '0) begin
            gpr[wb.rd] <= wb.data;
        end
    end

    assign rs_data = read_port(rs_addr, gpr[rs_addr], wb);
    assign rt_data = read_port(rt_addr, gpr[rt_addr], wb);

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the execute pipeline testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module exec_pipe_tb -f exec_pipe.f -o sim_exec_pipe

status=0
out=$(./obj_dir/sim_exec_pipe) || status=$?
echo "$out"

if [ "$status" -eq 0 ] && echo "$out" | grep -qF '** PASS **'; then
    exit 0
fi
echo "Simulation did not pass"
exit 1

// ==== testbench/exec_pipe_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_pipe_assertions (
    input wire                               ui_clk_from_ddr,
    input wire                               rst_n,
    input wire                               issue,
    input wire exec_pipe_pkg::micro_op_t     uop,
    input wire exec_pipe_pkg::stage_result_t wb
);

    ////////////////////////////////////////////////////////////
    // Reset behaviour
    ////////////////////////////////////////////////////////////
    // A reset edge leaves the writeback port quiet
    a_reset_quiet: assert property (@(posedge ui_clk_from_ddr)
        !rst_n |=> (!wb.retire && !wb.reg_w))
        else $error("wb.retire or wb.reg_w high after a reset edge");

    ////////////////////////////////////////////////////////////
    // Retire timing
    ////////////////////////////////////////////////////////////
    // Every issue retires three edges later with its own rd
    a_issue_retires: assert property (@(posedge ui_clk_from_ddr) disable iff (!rst_n)
        $past(issue, 3) |-> (wb.retire && wb.rd == $past(uop.rd, 3)))
        else $error("issued op did not retire on the third edge");

    // No retire without a matching issue
    a_retire_has_issue: assert property (@(posedge ui_clk_from_ddr) disable iff (!rst_n)
        wb.retire |-> $past(issue, 3))
        else $error("wb.retire high with no issue three edges earlier");

    // Writes only come from retiring ops and never target r0
    a_write_legal: assert property (@(posedge ui_clk_from_ddr) disable iff (!rst_n)
        wb.reg_w |-> (wb.retire && wb.rd != '0))
        else $error("wb.reg_w high without retire or with rd of zero");

endmodule

bind exec_pipe exec_pipe_assertions u_exec_pipe_assertions (
    .ui_clk_from_ddr ( ui_clk_from_ddr ),
    .rst_n           ( rst_n           ),
    .issue           ( issue           ),
    .uop             ( uop             ),
    .wb              ( wb              )
);

`default_nettype wire

// ==== testbench/exec_pipe_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "exec_pipe_defines.svh"

module exec_pipe_tb;

    localparam int MAX_CYCLES = 600;

    logic                         ui_clk_from_ddr;
    logic                         rst_n;
    logic                         issue;
    exec_pipe_pkg::micro_op_t     uop;
    exec_pipe_pkg::stage_result_t wb;

    exec_pipe_pkg::data_t         ref_regs [`EP_NUM_REGS];
    exec_pipe_pkg::stage_result_t exp_q [$];
    exec_pipe_pkg::stage_result_t exp_head;
    int                           pending;
    int                           cycles;
    int                           errors;
    int                           ops_issued;
    int                           last_rd [3];

    exec_pipe exec_pipe_inst (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .rst_n           ( rst_n           ),
        .issue           ( issue           ),
        .uop             ( uop             ),
        .wb              ( wb              )
    );

    initial begin
        ui_clk_from_ddr = 1'b0;
        forever #10 ui_clk_from_ddr = ~ui_clk_from_ddr;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////
    function automatic exec_pipe_pkg::stage_result_t apply_op(
        input exec_pipe_pkg::micro_op_t op
    );
        exec_pipe_pkg::stage_result_t r;
        exec_pipe_pkg::data_t         a;
        exec_pipe_pkg::data_t         b;
        exec_pipe_pkg::data_t         bv;
        exec_pipe_pkg::data_t         alu_res;
        exec_pipe_pkg::data_t         res;
        longint                       full;
        logic                         ovf;
        logic                         cond_ok;
        int                           amt;
        a   = ref_regs[op.rs];
        b   = ref_regs[op.rt];
        bv  = op.b_imm ? op.imm : b;
        ovf = 1'b0;
        full = 0;
        case (op.alu_op)
            exec_pipe_pkg::ALU_ADD, exec_pipe_pkg::ALU_ADDU: begin
                full    = longint'($signed(a)) + longint'($signed(bv));
                alu_res = full[31:0];
            end
            exec_pipe_pkg::ALU_SUB, exec_pipe_pkg::ALU_SUBU: begin
                full    = longint'($signed(a)) - longint'($signed(bv));
                alu_res = full[31:0];
            end
            exec_pipe_pkg::ALU_AND:  alu_res = a & bv;
            exec_pipe_pkg::ALU_OR:   alu_res = a | bv;
            exec_pipe_pkg::ALU_XOR:  alu_res = a ^ bv;
            exec_pipe_pkg::ALU_NOR:  alu_res = ~(a | bv);
            exec_pipe_pkg::ALU_SLT:  alu_res = ($signed(a) < $signed(bv)) ? 32'd1 : 32'd0;
            exec_pipe_pkg::ALU_SLTU: alu_res = (a < bv) ? 32'd1 : 32'd0;
            default:                 alu_res = {bv[15:0], 16'h0000};
        endcase
        // Signed overflow when the 32-bit result no longer equals the true sum
        if (op.alu_op == exec_pipe_pkg::ALU_ADD || op.alu_op == exec_pipe_pkg::ALU_SUB)
            ovf = (full != longint'($signed(alu_res)));
        amt = op.shamt_reg ? int'(a[4:0]) : int'(op.shamt);
        case (op.res_sel)
            exec_pipe_pkg::RES_SHIFT: begin
                if (op.shift_op == exec_pipe_pkg::SH_SLL)
                    res = b << amt;
                else if (op.shift_op == exec_pipe_pkg::SH_SRL)
                    res = b >> amt;
                else
                    res = $signed(b) >>> amt;
            end
            exec_pipe_pkg::RES_MOVE: res = a;
            default:                 res = alu_res;
        endcase
        case (op.move_cond)
            exec_pipe_pkg::MOVE_IF_ZERO:    cond_ok = (b == 0);
            exec_pipe_pkg::MOVE_IF_NONZERO: cond_ok = (b != 0);
            default:                        cond_ok = 1'b1;
        endcase
        r.retire = 1'b1;
        r.reg_w  = op.reg_w && !(op.trap_of && ovf) && cond_ok && (op.rd != 0);
        r.rd     = op.rd;
        r.data   = res;
        if (r.reg_w)
            ref_regs[op.rd] = res;
        return r;
    endfunction

    function automatic exec_pipe_pkg::micro_op_t blank_op();
        exec_pipe_pkg::micro_op_t op;
        op           = '0;
        op.alu_op    = exec_pipe_pkg::ALU_ADDU;
        op.res_sel   = exec_pipe_pkg::RES_ALU;
        op.move_cond = exec_pipe_pkg::MOVE_ALWAYS;
        op.reg_w     = 1'b1;
        return op;
    endfunction

    function automatic exec_pipe_pkg::micro_op_t imm_op(
        input exec_pipe_pkg::alu_op_e aop,
        input int                     rd,
        input int                     rs,
        input exec_pipe_pkg::data_t   imm,
        input logic                   trap
    );
        exec_pipe_pkg::micro_op_t op;
        op         = blank_op();
        op.alu_op  = aop;
        op.b_imm   = 1'b1;
        op.imm     = imm;
        op.rd      = 5'(rd);
        op.rs      = 5'(rs);
        op.trap_of = trap;
        return op;
    endfunction

    function automatic exec_pipe_pkg::micro_op_t random_op();
        exec_pipe_pkg::micro_op_t op;
        int                       kind;
        op   = blank_op();
        kind = $urandom_range(0, 2);
        op.rs  = 5'($urandom_range(0, 31));
        op.rt  = 5'($urandom_range(0, 31));
        op.rd  = 5'($urandom_range(0, 31));
        op.imm = $urandom;
        if (kind == 0) begin
            op.alu_op = exec_pipe_pkg::alu_op_e'(4'($urandom_range(0, 10)));
            op.b_imm  = 1'($urandom_range(0, 1));
            if (op.alu_op == exec_pipe_pkg::ALU_ADD || op.alu_op == exec_pipe_pkg::ALU_SUB)
                op.trap_of = 1'($urandom_range(0, 1));
        end else if (kind == 1) begin
            op.res_sel   = exec_pipe_pkg::RES_SHIFT;
            op.shift_op  = exec_pipe_pkg::shift_op_e'(2'($urandom_range(0, 2)));
            op.shamt_reg = 1'($urandom_range(0, 1));
            op.shamt     = 5'($urandom_range(0, 31));
        end else begin
            op.res_sel   = exec_pipe_pkg::RES_MOVE;
            op.move_cond = exec_pipe_pkg::move_cond_e'(2'($urandom_range(0, 2)));
        end
        return op;
    endfunction

    ////////////////////////////////////////////////////////////
    // Driving and scoreboard
    ////////////////////////////////////////////////////////////
    task automatic idle_cycle();
        @(posedge ui_clk_from_ddr);
        #2;
    endtask

    task automatic issue_op(input exec_pipe_pkg::micro_op_t op);
        uop   = op;
        issue = 1'b1;
        exp_q.push_back(apply_op(op));
        exp_head   = exp_q[0];
        pending    = exp_q.size();
        last_rd[2] = last_rd[1];
        last_rd[1] = last_rd[0];
        last_rd[0] = op.rd;
        ops_issued++;
        @(posedge ui_clk_from_ddr);
        #2;
        issue = 1'b0;
        // Occasional bubble
        if (ops_issued % 10 == 0)
            idle_cycle();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("FAIL at %0t ns: %s expected %h actual %h", $time, name, exp_v, act_v);
        $display("** FAIL **");
        $fatal(1, "Result mismatch");
    endtask

    task automatic report_unexpected();
        errors++;
        $display("Error at %0t ns: a result retired with no op outstanding", $time);
        $display("** FAIL **");
        $fatal(1, "Unexpected retire");
    endtask

    // Pop after the negedge checks have seen the retiring op
    always @(posedge ui_clk_from_ddr) begin
        if (rst_n && wb.retire && exp_q.size() != 0) begin
            void'(exp_q.pop_front());
            exp_head = (exp_q.size() != 0) ? exp_q[0] : '0;
            pending  = exp_q.size();
        end
    end

    a_retire_expected: assert property (@(negedge ui_clk_from_ddr) disable iff (!rst_n)
        wb.retire |-> pending != 0)
        else report_unexpected();

    a_reg_w_match: assert property (@(negedge ui_clk_from_ddr) disable iff (!rst_n)
        (wb.retire && pending != 0) |-> wb.reg_w == exp_head.reg_w)
        else report_mismatch("wb.reg_w", 32'(exp_head.reg_w), 32'(wb.reg_w));

    a_rd_match: assert property (@(negedge ui_clk_from_ddr) disable iff (!rst_n)
        (wb.retire && pending != 0) |-> wb.rd == exp_head.rd)
        else report_mismatch("wb.rd", 32'(exp_head.rd), 32'(wb.rd));

    a_data_match: assert property (@(negedge ui_clk_from_ddr) disable iff (!rst_n)
        (wb.retire && pending != 0 && exp_head.reg_w) |-> wb.data == exp_head.data)
        else report_mismatch("wb.data", exp_head.data, wb.data);

    always @(posedge ui_clk_from_ddr) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Error: simulation did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $fatal(1, "Timeout");
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////
    initial begin
        exec_pipe_pkg::micro_op_t op;
        int                       d;
        void'($urandom(74));
        rst_n      = 1'b0;
        issue      = 1'b0;
        uop        = '0;
        exp_head   = '0;
        pending    = 0;
        cycles     = 0;
        errors     = 0;
        ops_issued = 0;
        last_rd    = '{0, 0, 0};
        for (int i = 0; i < `EP_NUM_REGS; i++)
            ref_regs[i] = '0;
        repeat (16) @(posedge ui_clk_from_ddr);
        #2;
        rst_n = 1'b1;
        idle_cycle();

        // First op sees a cleared register file
        op    = blank_op();
        op.rd = 5'd1;
        op.rs = 5'd5;
        op.rt = 5'd9;
        issue_op(op);
        for (int r = 1; r < `EP_NUM_REGS; r++)
            issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, r, r, $urandom, 1'b0));

        // Sweep of operations and operand sources
        for (int i = 0; i <= 10; i++) begin
            op        = blank_op();
            op.alu_op = exec_pipe_pkg::alu_op_e'(4'(i));
            op.rd     = 5'(i + 10);
            op.rs     = 5'(i + 1);
            op.rt     = 5'(i + 2);
            issue_op(op);
        end
        for (int s = 0; s < 3; s++) begin
            for (int src = 0; src < 2; src++) begin
                op           = blank_op();
                op.res_sel   = exec_pipe_pkg::RES_SHIFT;
                op.shift_op  = exec_pipe_pkg::shift_op_e'(2'(s));
                op.shamt_reg = 1'(src);
                op.shamt     = 5'(7 * s + 3);
                op.rs        = 5'(s + 3);
                op.rt        = 5'(s + 20);
                op.rd        = 5'(s + 24);
                issue_op(op);
            end
        end

        // Independent random ops
        repeat (150)
            issue_op(random_op());

        // Chains reading a recent destination at distance 1 to 3
        repeat (170) begin
            op    = random_op();
            op.rd = 5'($urandom_range(1, 31));
            d     = $urandom_range(0, 2);
            if ($urandom_range(0, 1) == 1)
                op.rs = 5'(last_rd[d]);
            else
                op.rt = 5'(last_rd[d]);
            issue_op(op);
        end

        ////////////////////////////////////////////////////////////
        // Write suppression
        ////////////////////////////////////////////////////////////
        issue_op(imm_op(exec_pipe_pkg::ALU_LUI, 1, 0, 32'h7fff, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_OR, 1, 1, 32'hffff, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADD, 2, 1, 32'd1, 1'b1));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 3, 2, 32'd0, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_LUI, 4, 0, 32'h8000, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_SUB, 5, 4, 32'd1, 1'b1));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 6, 5, 32'd0, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 7, 0, 32'd5, 1'b0));
        op           = blank_op();
        op.res_sel   = exec_pipe_pkg::RES_MOVE;
        op.move_cond = exec_pipe_pkg::MOVE_IF_ZERO;
        op.rd        = 5'd8;
        op.rs        = 5'd6;
        op.rt        = 5'd7;
        issue_op(op);
        op.move_cond = exec_pipe_pkg::MOVE_IF_NONZERO;
        op.rt        = 5'd0;
        issue_op(op);
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 9, 8, 32'd0, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 0, 1, 32'd3, 1'b0));
        issue_op(imm_op(exec_pipe_pkg::ALU_ADDU, 10, 0, 32'd0, 1'b0));

        while (pending != 0)
            idle_cycle();
        repeat (2) idle_cycle();
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire
